// File: all.f
rtl/i2cPkg.sv
rtl/i2cCmdIf.sv
rtl/i2cByteIf.sv
rtl/cmdCapture.sv
rtl/byteSequencer.sv
rtl/bitEngine.sv
rtl/imgI2cMaster.sv
dv/i2cSlaveModel.sv
dv/tbImgI2cMaster.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tbImgI2cMaster --Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tbImgI2cMaster.sv
`default_nettype none

module tbImgI2cMaster import i2cPkg::*; ();
    localparam logic [DevAddrBits-1:0] SensorAddr = 7'h3c;
    localparam int TimeoutCycles = 5000;

    logic clk;
    logic reset;
    logic [DevAddrBits-1:0] cmdDevAddr;
    logic cmdWrite;
    logic [RegAddrBits-1:0] cmdRegAddr;
    logic cmdTwoBytes;
    logic [DataBits-1:0] cmdWriteData;
    logic cmdTrigger;
    logic statusDone;
    logic statusErr;
    logic [DataBits-1:0] statusReadData;
    logic i2cScl;
    logic i2cSdaLow;
    logic i2cSdaIn;

    int errorCount = 0;
    int testCount = 0;
    logic [31:0] rngState = 32'h3eeb2219;
    // Slave counters when the current command was issued
    int logBase;
    int stopBase;
    int repBase;
    int ackBase;
    int nackBase;

    imgI2cMaster #(
        .ClkFreq(1_600_000),
        .I2cClkFreq(100_000)
    ) u_imgI2cMaster (
        .clk(clk),
        .reset(reset),
        .cmdDevAddr(cmdDevAddr),
        .cmdWrite(cmdWrite),
        .cmdRegAddr(cmdRegAddr),
        .cmdTwoBytes(cmdTwoBytes),
        .cmdWriteData(cmdWriteData),
        .cmdTrigger(cmdTrigger),
        .statusDone(statusDone),
        .statusErr(statusErr),
        .statusReadData(statusReadData),
        .i2cScl(i2cScl),
        .i2cSdaLow(i2cSdaLow),
        .i2cSdaIn(i2cSdaIn)
    );

    i2cSlaveModel #(.DevAddr(SensorAddr)) slave (
        .clk(clk),
        .reset(reset),
        .scl(i2cScl),
        .masterLow(i2cSdaLow),
        .sda(i2cSdaIn)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkEqual(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %s finished, %0d errors so far", name, errorCount);
    endtask

    // Toggle handshake, then poll the done toggle
    task automatic issueCommand(
        input logic [DevAddrBits-1:0] devAddr,
        input logic write,
        input logic [RegAddrBits-1:0] regAddr,
        input logic twoBytes,
        input logic [DataBits-1:0] data,
        input string name
    );
        int cycles;
        logBase = slave.rxLog.size();
        stopBase = slave.stopCount;
        repBase = slave.repStartCount;
        ackBase = slave.ackCount;
        nackBase = slave.nackCount;
        @(posedge clk);
        #2;
        cmdDevAddr = devAddr;
        cmdWrite = write;
        cmdRegAddr = regAddr;
        cmdTwoBytes = twoBytes;
        cmdWriteData = data;
        cmdTrigger = !cmdTrigger;
        cycles = 0;
        while ((statusDone != cmdTrigger) && (cycles < TimeoutCycles)) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (statusDone != cmdTrigger) begin
            $display("Timeout: the %s transaction did not finish", name);
            errorCount++;
        end
    endtask

    // Byte i logged by the slave since the last command
    function automatic logic [31:0] logged(input int i);
        return 32'(slave.rxLog[logBase + i]);
    endfunction

    initial begin
        logic [15:0] reg2;
        logic [15:0] data2;
        logic [15:0] reg3;
        logic [15:0] data3;
        logic [7:0] snap [256];
        reset = 1'b1;
        cmdDevAddr = '0;
        cmdWrite = 1'b0;
        cmdRegAddr = '0;
        cmdTwoBytes = 1'b0;
        cmdWriteData = '0;
        cmdTrigger = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #1;

        // ====================
        // Idle bus after reset
        // ====================
        checkEqual(32'(i2cScl), 1, "SCL after reset");
        checkEqual(32'(i2cSdaLow), 0, "SDA pull-low after reset");
        checkEqual(32'(statusDone), 0, "statusDone after reset");
        checkEqual(32'(statusErr), 0, "statusErr after reset");
        checkEqual(32'(slave.startCount), 0, "starts after reset");
        endTest("reset");

        // Two-byte write to a random sensor register
        rngState = xorshift(rngState);
        reg2 = {8'h30, rngState[7:0]};
        data2 = rngState[23:8];
        issueCommand(SensorAddr, 1'b1, reg2, 1'b1, data2, "two-byte write");
        checkEqual(32'(slave.rxLog.size() - logBase), 5, "bytes logged");
        checkEqual(logged(0), {24'h0, SensorAddr, DirWrite}, "address byte");
        checkEqual(logged(1), 32'(reg2[15:8]), "register high");
        checkEqual(logged(2), 32'(reg2[7:0]), "register low");
        checkEqual(logged(3), 32'(data2[15:8]), "data high");
        checkEqual(logged(4), 32'(data2[7:0]), "data low");
        checkEqual(32'(slave.stopCount - stopBase), 1, "stops seen");
        checkEqual(32'(slave.regs[reg2[7:0]]), 32'(data2[15:8]), "stored high byte");
        checkEqual(32'(slave.regs[reg2[7:0] + 8'd1]), 32'(data2[7:0]), "stored low byte");
        checkEqual(32'(statusErr), 0, "statusErr");
        endTest("two-byte write");

        // One-byte write, nothing else may move
        rngState = xorshift(rngState);
        reg3 = reg2 + 16'h0010;
        data3 = rngState[15:0];
        for (int i = 0; i < 256; i++) begin
            snap[i] = slave.regs[i];
        end
        issueCommand(SensorAddr, 1'b1, reg3, 1'b0, data3, "one-byte write");
        checkEqual(32'(slave.rxLog.size() - logBase), 4, "bytes logged");
        checkEqual(logged(3), 32'(data3[7:0]), "data low");
        for (int i = 0; i < 256; i++) begin
            checkEqual(32'(slave.regs[i]), (8'(i) == reg3[7:0]) ? 32'(data3[7:0]) : 32'(snap[i]),
                       "register after one-byte write");
        end
        endTest("one-byte write");

        // ====================
        // Reads back
        // ====================
        issueCommand(SensorAddr, 1'b0, reg2, 1'b1, 16'h0, "two-byte read");
        checkEqual(32'(statusReadData), 32'(data2), "read data");
        checkEqual(32'(slave.repStartCount - repBase), 1, "repeated starts");
        checkEqual(logged(3), {24'h0, SensorAddr, DirRead}, "read address byte");
        checkEqual(32'(slave.ackCount - ackBase), 1, "master ACKs");
        checkEqual(32'(slave.nackCount - nackBase), 1, "master NACKs");
        issueCommand(SensorAddr, 1'b0, reg3, 1'b0, 16'h0, "one-byte read");
        checkEqual(32'(statusReadData), {24'h0, data3[7:0]}, "one-byte read data");
        checkEqual(32'(slave.ackCount - ackBase), 0, "master ACKs");
        endTest("reads");

        // Nobody answers 7'h21
        issueCommand(7'h21, 1'b1, reg2, 1'b1, 16'hbeef, "unanswered write");
        checkEqual(32'(statusErr), 1, "statusErr on NACK");
        checkEqual(32'(slave.rxLog.size() - logBase), 0, "bytes logged");
        checkEqual(32'(slave.stopCount - stopBase), 1, "stops seen");
        issueCommand(SensorAddr, 1'b0, reg3, 1'b0, 16'h0, "read after NACK");
        checkEqual(32'(statusErr), 0, "statusErr after valid command");
        checkEqual(32'(statusReadData), {24'h0, data3[7:0]}, "read data after NACK");
        endTest("unanswered address");

        checkEqual(32'(slave.protoErrors), 0, "protocol assertion failures");
        endTest("protocol");

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/i2cSlaveModel.sv
`default_nettype none

// Behavioral image sensor on the I2C bus
module i2cSlaveModel import i2cPkg::*; #(
    parameter logic [DevAddrBits-1:0] DevAddr = 7'h3c
) (
    input logic clk,
    input logic reset,
    input logic scl,
    input logic masterLow,
    output logic sda
);
    // Pull-up wins unless somebody pulls low
    logic slaveLow;
    assign sda = !(masterLow || slaveLow);

    logic prevScl;
    logic prevSda;
    logic active;
    logic addressed;
    logic sending;
    logic ackSlot;
    logic masterAcked;
    logic [3:0] bitCnt;
    int byteIdx;
    logic [ByteBits-1:0] shift;
    logic [ByteBits-1:0] txShift;
    logic [ByteBits-1:0] regPtr;

    // Register file, byte log and event counters read by the testbench
    logic [ByteBits-1:0] regs [256];
    logic [ByteBits-1:0] rxLog [$];
    int startCount;
    int repStartCount;
    int stopCount;
    int ackCount;
    int nackCount;
    int protoErrors;

    initial begin
        // Fill pattern from the whole index
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'(i) ^ 8'h5a;
        end
        startCount = 0;
        repStartCount = 0;
        stopCount = 0;
        ackCount = 0;
        nackCount = 0;
        protoErrors = 0;
    end

    // ====================
    // Bus decoding
    // ====================
    always @(posedge clk) begin
        prevScl <= scl;
        prevSda <= sda;
        if (reset) begin
            active <= 1'b0;
            slaveLow <= 1'b0;
            ackSlot <= 1'b0;
            sending <= 1'b0;
            bitCnt <= '0;
        end else if (scl && prevScl && prevSda && !sda) begin
            // Start or repeated start
            if (active) begin
                repStartCount <= repStartCount + 1;
            end else begin
                startCount <= startCount + 1;
            end
            active <= 1'b1;
            addressed <= 1'b0;
            sending <= 1'b0;
            ackSlot <= 1'b0;
            bitCnt <= '0;
            byteIdx <= 0;
            slaveLow <= 1'b0;
        end else if (scl && prevScl && !prevSda && sda) begin
            stopCount <= stopCount + 1;
            active <= 1'b0;
            slaveLow <= 1'b0;
        end else if (active && scl && !prevScl) begin
            // Rising SCL, sample the bit
            if (ackSlot) begin
                // Master ACK slots follow data bytes only, not our address ACK
                if (sending && (byteIdx > 1)) begin
                    if (!sda) begin
                        ackCount <= ackCount + 1;
                    end else begin
                        nackCount <= nackCount + 1;
                    end
                    masterAcked <= !sda;
                end
            end else begin
                if (!sending) begin
                    shift <= {shift[ByteBits-2:0], sda};
                end
                bitCnt <= bitCnt + 1'b1;
            end
        end else if (active && !scl && prevScl) begin
            // Falling SCL, move our own SDA
            if (ackSlot) begin
                ackSlot <= 1'b0;
                bitCnt <= '0;
                slaveLow <= 1'b0;
                if (addressed && sending && masterAcked) begin
                    txShift <= regs[regPtr];
                    slaveLow <= !regs[regPtr][ByteBits-1];
                    regPtr <= regPtr + 1'b1;
                end else if (sending) begin
                    // Master NACK ends the read
                    sending <= 1'b0;
                end
            end else if (bitCnt == 4'd8) begin
                ackSlot <= 1'b1;
                if (sending) begin
                    slaveLow <= 1'b0;
                end else if (byteIdx == 0) begin
                    addressed <= (shift[ByteBits-1:1] == DevAddr);
                    if (shift[ByteBits-1:1] == DevAddr) begin
                        rxLog.push_back(shift);
                        slaveLow <= 1'b1;
                        if (shift[0] == DirRead) begin
                            sending <= 1'b1;
                            masterAcked <= 1'b1;
                        end
                    end
                end else if (addressed) begin
                    rxLog.push_back(shift);
                    slaveLow <= 1'b1;
                    // Index is the low register-address byte
                    if (byteIdx == 2) begin
                        regPtr <= shift;
                    end else if (byteIdx > 2) begin
                        regs[regPtr] <= shift;
                        regPtr <= regPtr + 1'b1;
                    end
                end
                byteIdx <= byteIdx + 1;
            end else if (sending) begin
                slaveLow <= !txShift[3'd7 - bitCnt[2:0]];
            end
        end
    end

    // ====================
    // Protocol checks
    // ====================
    // SDA holds across every SCL edge
    sclEdgeHold: assert property (@(posedge clk) disable iff (reset)
        (scl != $past(scl)) |-> (sda == $past(sda)))
        else begin
            $display("Error at %0t: SDA moved together with SCL", $time);
            protoErrors++;
        end

    // Under SCL high SDA moves only between bytes, as a start or stop
    highSdaStartStop: assert property (@(posedge clk) disable iff (reset)
        (scl && $past(scl) && (sda != $past(sda))) |->
            (!active || (!ackSlot && (bitCnt <= 4'd1))))
        else begin
            $display("Error at %0t: SDA changed under SCL high outside start or stop", $time);
            protoErrors++;
        end

endmodule

`default_nettype wire

// File: rtl/imgI2cMaster.sv
`default_nettype none

module imgI2cMaster import i2cPkg::*; #(
    parameter int ClkFreq = 24_000_000,
    parameter int I2cClkFreq = 400_000
) (
    input logic clk,
    input logic reset,
    // Host command, fields stable while a toggle is pending
    input logic [DevAddrBits-1:0] cmdDevAddr,
    input logic cmdWrite,
    input logic [RegAddrBits-1:0] cmdRegAddr,
    input logic cmdTwoBytes,
    input logic [DataBits-1:0] cmdWriteData,
    input logic cmdTrigger,
    // Status, statusDone follows cmdTrigger
    output logic statusDone,
    output logic statusErr,
    output logic [DataBits-1:0] statusReadData,
    // Bus, open drain and pull-up live outside
    output logic i2cScl,
    output logic i2cSdaLow,
    input logic i2cSdaIn
);
    i2cCmdIf cmdLink ();
    i2cByteIf byteLink ();

    cmdCapture u_cmdCapture (
        .clk(clk),
        .reset(reset),
        .cmdDevAddr(cmdDevAddr),
        .cmdWrite(cmdWrite),
        .cmdRegAddr(cmdRegAddr),
        .cmdTwoBytes(cmdTwoBytes),
        .cmdWriteData(cmdWriteData),
        .cmdTrigger(cmdTrigger),
        .statusDone(statusDone),
        .statusErr(statusErr),
        .statusReadData(statusReadData),
        .cmd(cmdLink.capture)
    );

    byteSequencer u_byteSequencer (
        .clk(clk),
        .reset(reset),
        .cmd(cmdLink.sequencer),
        .bus(byteLink.sequencer)
    );

    bitEngine #(
        .ClkFreq(ClkFreq),
        .I2cClkFreq(I2cClkFreq)
    ) u_bitEngine (
        .clk(clk),
        .reset(reset),
        .bus(byteLink.engine),
        .i2cScl(i2cScl),
        .i2cSdaLow(i2cSdaLow),
        .i2cSdaIn(i2cSdaIn)
    );

endmodule

`default_nettype wire

// File: rtl/bitEngine.sv
`default_nettype none

module bitEngine import i2cPkg::*; #(
    parameter int ClkFreq = 24_000_000,
    parameter int I2cClkFreq = 400_000
) (
    input logic clk,
    input logic reset,
    i2cByteIf.engine bus,
    output logic i2cScl,
    output logic i2cSdaLow,
    input logic i2cSdaIn
);
    localparam int Quarter = quarterCycles(ClkFreq, I2cClkFreq);
    localparam int TimerBits = $clog2(Quarter);
    // Byte ops run 9 bits of 4 quarters, phase 0 to 35
    localparam int PhaseBits = 6;

    logic busy;
    busOp_t opReg;
    logic [PhaseBits-1:0] phase;
    logic [TimerBits-1:0] timer;
    logic [ByteBits-1:0] txReg;
    logic ackReg;
    logic [ByteBits-1:0] rxReg;
    logic nackReg;

    logic quarterEnd;
    logic lastQuarter;
    logic take;
    logic advance;
    logic [3:0] bitIdx;
    logic ackSlot;
    logic sampleNow;

    busOp_t nextOp;
    logic [PhaseBits-1:0] nextPhase;
    logic [ByteBits-1:0] nextTx;
    logic nextAck;
    logic [1:0] nextLevels;

    // Final quarter index of each operation
    function automatic logic [PhaseBits-1:0] lastPhase(input busOp_t op);
        logic [PhaseBits-1:0] result;
        case (op)
            opStart, opStop: result = 6'd2;
            opRepStart: result = 6'd3;
            default: result = 6'd35;
        endcase
        return result;
    endfunction

    // SCL and SDA pull-low for one quarter, as {scl, sdaLow}
    function automatic logic [1:0] busLevels(
        input busOp_t op,
        input logic [PhaseBits-1:0] ph,
        input logic [ByteBits-1:0] tx,
        input logic ack
    );
        logic [3:0] bitNum;
        logic slot9;
        logic scl;
        logic sdaLow;
        bitNum = ph[PhaseBits-1:2];
        slot9 = (bitNum == 4'd8);
        // Byte bits: SCL high in the two middle quarters
        scl = (ph[1:0] == 2'd1) || (ph[1:0] == 2'd2);
        sdaLow = 1'b0;
        case (op)
            // SDA falls while SCL high, then SCL low
            opStart: begin
                scl = (ph != 6'd2);
                sdaLow = (ph != 6'd0);
            end
            // Release SDA, raise SCL, then a fresh start edge
            opRepStart: begin
                scl = (ph == 6'd1) || (ph == 6'd2);
                sdaLow = (ph == 6'd2) || (ph == 6'd3);
            end
            // SDA low, SCL up, then SDA rises
            opStop: begin
                scl = (ph != 6'd0);
                sdaLow = (ph != 6'd2);
            end
            // MSB first, released for the slave ACK
            opWriteByte: sdaLow = !slot9 && !tx[~bitNum[2:0]];
            // Slave drives data, master drives the ninth bit
            default: sdaLow = slot9 && ack;
        endcase
        return {scl, sdaLow};
    endfunction

    // ====================
    // Sequencing
    // ====================
    assign quarterEnd = busy && (timer == '0);
    assign lastQuarter = (phase == lastPhase(opReg));
    // Next op starts in the cycle after the last one ends, no gap
    assign take = bus.opValid && (!busy || (quarterEnd && lastQuarter));
    assign advance = quarterEnd && !lastQuarter;

    // Done one cycle early so the next request is up in time
    assign bus.opDone = busy && lastQuarter && (timer == TimerBits'(1));
    assign bus.rxByte = rxReg;
    assign bus.slaveNack = nackReg;

    assign bitIdx = phase[PhaseBits-1:2];
    assign ackSlot = (bitIdx == 4'd8);
    // End of the first high quarter is the middle of SCL high
    assign sampleNow = quarterEnd && (phase[1:0] == 2'd1);

    assign nextOp = take ? bus.op : opReg;
    assign nextPhase = take ? '0 : phase + 1'b1;
    assign nextTx = take ? bus.txByte : txReg;
    assign nextAck = take ? bus.masterAck : ackReg;
    assign nextLevels = busLevels(nextOp, nextPhase, nextTx, nextAck);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            phase <= '0;
            timer <= '0;
            i2cScl <= 1'b1;
            i2cSdaLow <= 1'b0;
        end else begin
            if (take || advance) begin
                timer <= TimerBits'(Quarter - 1);
                phase <= nextPhase;
                {i2cScl, i2cSdaLow} <= nextLevels;
            end else if (busy && !quarterEnd) begin
                timer <= timer - 1'b1;
            end
            // Bus lines hold their last levels while idle
            if (take) begin
                busy <= 1'b1;
            end else if (quarterEnd && lastQuarter) begin
                busy <= 1'b0;
            end
        end
    end

    // Request copy and sampled SDA
    always_ff @(posedge clk) begin
        if (take) begin
            opReg <= bus.op;
            txReg <= bus.txByte;
            ackReg <= bus.masterAck;
        end
        if (sampleNow && (opReg == opWriteByte) && ackSlot) begin
            nackReg <= i2cSdaIn;
        end
        if (sampleNow && (opReg == opReadByte) && !ackSlot) begin
            rxReg <= {rxReg[ByteBits-2:0], i2cSdaIn};
        end
    end

endmodule

`default_nettype wire

// File: rtl/byteSequencer.sv
`default_nettype none

module byteSequencer import i2cPkg::*; (
    input logic clk,
    input logic reset,
    i2cCmdIf.sequencer cmd,
    i2cByteIf.sequencer bus
);
    // One step per bus operation, plus idle and done
    localparam logic [3:0] StIdle = 4'd0;
    localparam logic [3:0] StStart = 4'd1;
    localparam logic [3:0] StAddrW = 4'd2;
    localparam logic [3:0] StRegHi = 4'd3;
    localparam logic [3:0] StRegLo = 4'd4;
    localparam logic [3:0] StWrHi = 4'd5;
    localparam logic [3:0] StWrLo = 4'd6;
    localparam logic [3:0] StRepStart = 4'd7;
    localparam logic [3:0] StAddrR = 4'd8;
    localparam logic [3:0] StRdHi = 4'd9;
    localparam logic [3:0] StRdLo = 4'd10;
    localparam logic [3:0] StStop = 4'd11;
    localparam logic [3:0] StDone = 4'd12;

    logic [3:0] state;
    logic [3:0] nextState;
    logic accept;
    logic writeStep;
    logic nackHit;
    logic nackFlag;
    logic [DataBits-1:0] readWord;

    // Request for the step being entered
    logic nextValid;
    busOp_t nextOp;
    logic [ByteBits-1:0] nextTx;
    logic nextAck;

    assign accept = (state == StIdle) && cmd.cmdValid;

    // Bytes the slave has to ACK
    assign writeStep = (state == StAddrW) || (state == StRegHi) ||
                       (state == StRegLo) || (state == StWrHi) ||
                       (state == StWrLo) || (state == StAddrR);
    assign nackHit = bus.opDone && writeStep && bus.slaveNack;

    // ====================
    // Step order
    // ====================
    always_comb begin
        nextState = state;
        case (state)
            StIdle: begin
                if (cmd.cmdValid) begin
                    nextState = StStart;
                end
            end
            StDone: begin
                nextState = StIdle;
            end
            default: begin
                if (nackHit) begin
                    // Slave refused a byte, close the bus right away
                    nextState = StStop;
                end else if (bus.opDone) begin
                    case (state)
                        StStart: nextState = StAddrW;
                        StAddrW: nextState = StRegHi;
                        StRegHi: nextState = StRegLo;
                        StRegLo: begin
                            if (cmd.write) begin
                                nextState = cmd.twoBytes ? StWrHi : StWrLo;
                            end else begin
                                nextState = StRepStart;
                            end
                        end
                        StWrHi: nextState = StWrLo;
                        StRepStart: nextState = StAddrR;
                        StAddrR: nextState = cmd.twoBytes ? StRdHi : StRdLo;
                        StRdHi: nextState = StRdLo;
                        StStop: nextState = StDone;
                        // Last data byte either way
                        default: nextState = StStop;
                    endcase
                end
            end
        endcase
    end

    // ====================
    // Operation per step
    // ====================
    always_comb begin
        nextValid = 1'b1;
        nextOp = opWriteByte;
        nextTx = '1;
        nextAck = 1'b0;
        case (nextState)
            StStart: nextOp = opStart;
            // Address phase always goes out as a write
            StAddrW: nextTx = {cmd.devAddr, DirWrite};
            StRegHi: nextTx = cmd.regAddr[RegAddrBits-1 -: ByteBits];
            StRegLo: nextTx = cmd.regAddr[ByteBits-1:0];
            StWrHi: nextTx = cmd.writeData[DataBits-1 -: ByteBits];
            StWrLo: nextTx = cmd.writeData[ByteBits-1:0];
            StRepStart: nextOp = opRepStart;
            StAddrR: nextTx = {cmd.devAddr, DirRead};
            StRdHi: begin
                // More to come, so ACK
                nextOp = opReadByte;
                nextAck = 1'b1;
            end
            // Final byte gets a NACK
            StRdLo: nextOp = opReadByte;
            StStop: nextOp = opStop;
            default: nextValid = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= StIdle;
            bus.opValid <= 1'b0;
            nackFlag <= 1'b0;
        end else begin
            state <= nextState;
            bus.opValid <= nextValid;
            if (accept) begin
                nackFlag <= 1'b0;
            end else if (nackHit) begin
                nackFlag <= 1'b1;
            end
        end
    end

    // Request fields follow the step, read word collects bytes MSB first
    always_ff @(posedge clk) begin
        bus.op <= nextOp;
        bus.txByte <= nextTx;
        bus.masterAck <= nextAck;
        if (accept) begin
            readWord <= '0;
        end else if (bus.opDone && ((state == StRdHi) || (state == StRdLo))) begin
            readWord <= {readWord[DataBits-ByteBits-1:0], bus.rxByte};
        end
    end

    assign cmd.cmdDone = (state == StDone);
    assign cmd.nackErr = nackFlag;
    assign cmd.readData = readWord;

endmodule

`default_nettype wire

// File: rtl/cmdCapture.sv
`default_nettype none

module cmdCapture import i2cPkg::*; (
    input logic clk,
    input logic reset,
    input logic [DevAddrBits-1:0] cmdDevAddr,
    input logic cmdWrite,
    input logic [RegAddrBits-1:0] cmdRegAddr,
    input logic cmdTwoBytes,
    input logic [DataBits-1:0] cmdWriteData,
    input logic cmdTrigger,
    output logic statusDone,
    output logic statusErr,
    output logic [DataBits-1:0] statusReadData,
    i2cCmdIf.capture cmd
);
    // Sampled host toggle
    logic triggerSeen;
    logic accept;

    // Pending while the toggles differ, taken once the chain is free
    assign accept = !cmd.cmdValid && (triggerSeen != statusDone);

    // ====================
    // Handshake and status
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            triggerSeen <= 1'b0;
            cmd.cmdValid <= 1'b0;
            statusDone <= 1'b0;
            statusErr <= 1'b0;
            statusReadData <= '0;
        end else begin
            triggerSeen <= cmdTrigger;
            if (cmd.cmdDone) begin
                // Results land together with the done toggle
                cmd.cmdValid <= 1'b0;
                statusDone <= !statusDone;
                statusErr <= cmd.nackErr;
                statusReadData <= cmd.readData;
            end else if (accept) begin
                cmd.cmdValid <= 1'b1;
            end
        end
    end

    // Command fields, frozen for the whole transaction
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.devAddr <= cmdDevAddr;
            cmd.write <= cmdWrite;
            cmd.regAddr <= cmdRegAddr;
            cmd.twoBytes <= cmdTwoBytes;
            cmd.writeData <= cmdWriteData;
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2cByteIf.sv
`default_nettype none

// One bus operation at a time between sequencer and bit engine
interface i2cByteIf import i2cPkg::*; ();

    // Request, held until opDone
    logic opValid;
    busOp_t op;
    logic [ByteBits-1:0] txByte;
    // Drive ACK after a read byte, NACK when low
    logic masterAck;

    // Completion and what came back from the slave
    logic opDone;
    logic [ByteBits-1:0] rxByte;
    logic slaveNack;

    modport sequencer(
        output opValid, op, txByte, masterAck,
        input opDone, rxByte, slaveNack
    );

    modport engine(
        input opValid, op, txByte, masterAck,
        output opDone, rxByte, slaveNack
    );

endinterface

`default_nettype wire

// File: rtl/i2cCmdIf.sv
`default_nettype none

// Latched command out, completion and results back
interface i2cCmdIf import i2cPkg::*; ();

    // Command, held from acceptance until cmdDone
    logic cmdValid;
    logic [DevAddrBits-1:0] devAddr;
    logic write;
    logic [RegAddrBits-1:0] regAddr;
    logic twoBytes;
    logic [DataBits-1:0] writeData;

    // One-cycle pulse after the stop, results valid with it
    logic cmdDone;
    logic nackErr;
    logic [DataBits-1:0] readData;

    modport capture(
        output cmdValid, devAddr, write, regAddr, twoBytes, writeData,
        input cmdDone, nackErr, readData
    );

    modport sequencer(
        input cmdValid, devAddr, write, regAddr, twoBytes, writeData,
        output cmdDone, nackErr, readData
    );

endinterface

`default_nettype wire

// File: rtl/i2cPkg.sv
`default_nettype none

package i2cPkg;

    // ====================
    // Field widths
    // ====================

    // 7-bit sensor device address
    localparam int DevAddrBits = 7;
    // 16-bit sensor register address
    localparam int RegAddrBits = 16;
    // Data word, one or two bytes on the bus
    localparam int DataBits = 16;
    // Bits per bus byte
    localparam int ByteBits = 8;

    // Direction bit after the device address
    localparam logic DirWrite = 1'b0;
    localparam logic DirRead = 1'b1;

    // ====================
    // Bus operations
    // ====================

    // One operation per call into the bit engine
    typedef enum logic [2:0] {
        opStart,
        opRepStart,
        opWriteByte,
        opReadByte,
        opStop
    } busOp_t;

    // Clock cycles per quarter of the bus period
    // Rounded up so the bus never runs faster than requested
    // Floor of 2 leaves the slave time to turn SDA around
    function automatic int quarterCycles(input int clkFreq, input int i2cClkFreq);
        int cycles;
        cycles = (clkFreq + 4 * i2cClkFreq - 1) / (4 * i2cClkFreq);
        return (cycles < 2) ? 2 : cycles;
    endfunction

endpackage

`default_nettype wire
